//--- icache_pkg.sv
package icache_pkg;

   // Address and data widths
   localparam int ADDR_W = 32;
   localparam int WORD_W = 32;

   // Line geometry, 16-byte lines of 32-bit words
   localparam int LINE_BYTES_LOG2 = 4;
   localparam int WORD_BYTES_LOG2 = 2;
   localparam int BEAT_CNT_W = LINE_BYTES_LOG2 - WORD_BYTES_LOG2;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [WORD_W-1:0] word_t;

   // Main controller states
   typedef enum logic [2:0] {
      ST_BOOT,
      ST_IDLE,
      ST_REFILL,
      ST_READOUT,
      ST_INV_READ,
      ST_INV_CLEAR
   } icache_state_e;

endpackage

//--- icache_sdp_ram.sv
`timescale 1ns/100ps

module icache_sdp_ram #(
   parameter int AW = 4,
   parameter int DW = 32
) (
   input  logic          clk,
   input  logic          re,
   input  logic [AW-1:0] raddr,
   input  logic          we,
   input  logic [AW-1:0] waddr,
   input  logic [DW-1:0] wdata,
   output logic [DW-1:0] rdata
);

   logic [DW-1:0] mem [1 << AW];

   always_ff @(posedge clk)
   begin
      if (we)
         mem[waddr] <= wdata;
      // Output register holds while re is low
      // A write to the address being read is forwarded
      if (re)
         rdata <= (we && (waddr == raddr)) ? wdata : mem[raddr];
   end

endmodule

//--- icache_tag_store.sv
`timescale 1ns/100ps

module icache_tag_store #(
   parameter int SETS_LOG2 = 4,
   parameter int WAYS_LOG2 = 2,
   localparam int WAYS = 1 << WAYS_LOG2,
   localparam int TAG_W = icache_pkg::ADDR_W - SETS_LOG2 - icache_pkg::LINE_BYTES_LOG2
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             rd_en,
   input  logic [SETS_LOG2-1:0]             rd_idx,
   input  logic [SETS_LOG2-1:0]             wr_idx,
   input  logic [WAYS-1:0]                  tag_we,
   input  logic [WAYS-1:0]                  rank_we,
   input  logic [WAYS-1:0][TAG_W:0]         tag_wdata,
   input  logic [WAYS-1:0][WAYS_LOG2-1:0]   rank_wdata,
   output logic [WAYS-1:0][TAG_W:0]         tag_rdata,
   output logic [WAYS-1:0][WAYS_LOG2-1:0]   rank_rdata
);

   // Set by the first read after reset, until then RAM outputs are junk
   logic rd_ok;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rd_ok <= 1'b0;
      else if (rd_en)
         rd_ok <= 1'b1;
   end

   for (genvar i = 0; i < WAYS; i++)
   begin : gen_way
      logic [TAG_W:0] tag_raw;

      // Valid bit on top, tag below
      icache_sdp_ram #(.AW(SETS_LOG2), .DW(TAG_W + 1)) tag_ram_inst (
         .clk   (clk),
         .re    (rd_en),
         .raddr (rd_idx),
         .we    (tag_we[i]),
         .waddr (wr_idx),
         .wdata ({tag_wdata[i][TAG_W], tag_wdata[i][TAG_W-1:0]}),
         .rdata (tag_raw)
      );

      icache_sdp_ram #(.AW(SETS_LOG2), .DW(WAYS_LOG2)) rank_ram_inst (
         .clk   (clk),
         .re    (rd_en),
         .raddr (rd_idx),
         .we    (rank_we[i]),
         .waddr (wr_idx),
         .wdata (rank_wdata[i]),
         .rdata (rank_rdata[i])
      );

      assign tag_rdata[i] = {tag_raw[TAG_W] & rd_ok, tag_raw[TAG_W-1:0]};
   end

endmodule

//--- icache_way_select.sv
`timescale 1ns/100ps

module icache_way_select #(
   parameter int SETS_LOG2 = 4,
   parameter int WAYS_LOG2 = 2,
   localparam int WAYS = 1 << WAYS_LOG2,
   localparam int TAG_W = icache_pkg::ADDR_W - SETS_LOG2 - icache_pkg::LINE_BYTES_LOG2
) (
   input  icache_pkg::icache_state_e        state,
   input  logic                             s1_valid,
   input  icache_pkg::addr_t                s1_addr,
   input  logic [SETS_LOG2-1:0]             boot_idx,
   input  logic [WAYS-1:0][TAG_W:0]         tag_rdata,
   input  logic [WAYS-1:0][WAYS_LOG2-1:0]   rank_rdata,
   output logic                             hit,
   output logic [WAYS_LOG2-1:0]             hit_way,
   output logic [WAYS_LOG2-1:0]             victim_way,
   output logic [WAYS-1:0]                  tag_we,
   output logic [WAYS-1:0][TAG_W:0]         tag_wdata,
   output logic [WAYS-1:0]                  rank_we,
   output logic [WAYS-1:0][WAYS_LOG2-1:0]   rank_wdata
);

   import icache_pkg::*;

   logic [TAG_W-1:0]     s1_tag;
   logic [TAG_W-1:0]     boot_stamp;
   logic [WAYS-1:0]      match;
   logic [WAYS_LOG2-1:0] hit_rank;

   assign s1_tag = s1_addr[ADDR_W-1 -: TAG_W];

   // Cleared entries carry their set number, easier to spot in a RAM dump
   assign boot_stamp = TAG_W'(boot_idx);

   for (genvar i = 0; i < WAYS; i++)
   begin : gen_match
      assign match[i] = tag_rdata[i][TAG_W] && (tag_rdata[i][TAG_W-1:0] == s1_tag);
   end

   assign hit = |match;

   // Way encoders, at most one match and one rank-0 way per set
   always_comb
   begin
      hit_way = '0;
      victim_way = '0;
      for (int i = 0; i < WAYS; i++)
      begin
         if (match[i])
            hit_way = WAYS_LOG2'(i);
         if (rank_rdata[i] == '0)
            victim_way = WAYS_LOG2'(i);
      end
   end

   assign hit_rank = rank_rdata[hit_way];

   always_comb
   begin
      tag_we = '0;
      rank_we = '0;
      for (int i = 0; i < WAYS; i++)
      begin
         tag_wdata[i] = tag_rdata[i];
         rank_wdata[i] = rank_rdata[i];
      end

      case (state)
         ST_BOOT:
         begin
            tag_we = '1;
            rank_we = '1;
            for (int i = 0; i < WAYS; i++)
            begin
               tag_wdata[i] = {1'b0, boot_stamp};
               rank_wdata[i] = WAYS_LOG2'(i);
            end
         end
         ST_IDLE:
         begin
            if (s1_valid && hit)
            begin
               // Hit way goes to the top, ways above its old rank move down
               rank_we = '1;
               for (int i = 0; i < WAYS; i++)
               begin
                  if (match[i])
                     rank_wdata[i] = '1;
                  else
                     rank_wdata[i] = rank_rdata[i] - WAYS_LOG2'(rank_rdata[i] > hit_rank);
               end
            end
            else if (s1_valid)
            begin
               // Claim the LRU way now, data follows during refill
               tag_we[victim_way] = 1'b1;
               tag_wdata[victim_way] = {1'b1, s1_tag};
            end
         end
         ST_INV_CLEAR:
         begin
            tag_we = match;
            for (int i = 0; i < WAYS; i++)
               tag_wdata[i][TAG_W] = 1'b0;
         end
         default:
         begin
         end
      endcase
   end

endmodule

//--- icache_data_store.sv
`timescale 1ns/100ps

module icache_data_store #(
   parameter int SETS_LOG2 = 4,
   parameter int WAYS_LOG2 = 2,
   localparam int WAYS = 1 << WAYS_LOG2,
   localparam int RAM_AW = SETS_LOG2 + icache_pkg::BEAT_CNT_W
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 rd_en,
   input  logic [RAM_AW-1:0]    rd_addr,
   input  logic [WAYS_LOG2-1:0] refill_way,
   input  logic [SETS_LOG2-1:0] refill_set,
   input  logic                 r_valid,
   input  logic                 r_ready,
   input  icache_pkg::word_t    r_data,
   input  logic [WAYS_LOG2-1:0] hit_way,
   output icache_pkg::word_t    dout,
   output logic                 line_done
);

   import icache_pkg::*;

   logic                  beat;
   logic [BEAT_CNT_W-1:0] beat_cnt;
   word_t                 way_rdata [WAYS];

   assign beat = r_valid && r_ready;

   // Word offset of the next beat, wraps at the end of each line
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         beat_cnt <= '0;
      else if (beat)
         beat_cnt <= beat_cnt + 1'b1;
   end

   assign line_done = beat && (&beat_cnt);

   for (genvar i = 0; i < WAYS; i++)
   begin : gen_way
      logic way_we;

      assign way_we = beat && (refill_way == WAYS_LOG2'(i));

      icache_sdp_ram #(.AW(RAM_AW), .DW(WORD_W)) data_ram_inst (
         .clk   (clk),
         .re    (rd_en),
         .raddr (rd_addr),
         .we    (way_we),
         .waddr ({refill_set, beat_cnt}),
         .wdata (r_data),
         .rdata (way_rdata[i])
      );
   end

   // Word of the way that matched in stage 1
   assign dout = way_rdata[hit_way];

endmodule

//--- icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl #(
   parameter int SETS_LOG2 = 4
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      s1_valid,
   input  icache_pkg::addr_t         s1_addr,
   input  logic                      hit,
   input  logic                      line_done,
   input  logic                      inv_we,
   input  icache_pkg::addr_t         inv_addr,
   input  logic                      ar_ready,
   output icache_pkg::icache_state_e state,
   output logic [SETS_LOG2-1:0]      boot_idx,
   output icache_pkg::addr_t         inv_line_addr,
   output logic                      stall,
   output logic                      dout_vld,
   output logic                      inv_busy,
   output logic                      ar_valid,
   output icache_pkg::addr_t         ar_addr,
   output logic                      r_ready
);

   import icache_pkg::*;

   icache_state_e state_nxt;
   logic          miss;
   logic          inv_start;
   logic          refill_start;
   logic          inv_pending;

   assign miss = s1_valid && !hit;
   assign refill_start = (state == ST_IDLE) && miss;

   // A stage-1 miss holds the front end, so inv_we cannot meet it
   assign inv_start = (state == ST_IDLE) && inv_we && !miss;

   always_comb
   begin
      state_nxt = state;
      case (state)
         ST_BOOT:
         begin
            if (boot_idx == '0)
               state_nxt = ST_READOUT;
         end
         ST_IDLE:
         begin
            if (refill_start)
               state_nxt = ST_REFILL;
            else if (inv_start)
               state_nxt = ST_INV_READ;
         end
         ST_REFILL:
         begin
            if (line_done)
               state_nxt = ST_READOUT;
         end
         ST_INV_READ:
            state_nxt = ST_INV_CLEAR;
         ST_INV_CLEAR:
            state_nxt = ST_READOUT;
         // Tags and data re-read at the stage-1 address
         ST_READOUT:
            state_nxt = ST_IDLE;
         default:
            state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= ST_BOOT;
      else
         state <= state_nxt;
   end

   // Sweep counter, one set per boot cycle, counting down
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         boot_idx <= '1;
      else if (state == ST_BOOT)
         boot_idx <= boot_idx - 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (inv_start)
         inv_line_addr <= {inv_addr[ADDR_W-1:LINE_BYTES_LOG2], {LINE_BYTES_LOG2{1'b0}}};
   end

   // Covers INV_READ, INV_CLEAR and the READOUT after them
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         inv_pending <= 1'b0;
      else if (inv_start)
         inv_pending <= 1'b1;
      else if (state == ST_READOUT)
         inv_pending <= 1'b0;
   end

   assign inv_busy = inv_pending;

   // Address request stays up until the slave takes it
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ar_valid <= 1'b0;
      else if (refill_start)
         ar_valid <= 1'b1;
      else if (ar_ready)
         ar_valid <= 1'b0;
   end

   assign ar_addr = {s1_addr[ADDR_W-1:LINE_BYTES_LOG2], {LINE_BYTES_LOG2{1'b0}}};
   assign r_ready = (state == ST_REFILL);

   assign stall = (state != ST_IDLE) || miss;
   assign dout_vld = (state == ST_IDLE) && s1_valid && hit;

endmodule

//--- icache_top.sv
`timescale 1ns/100ps

module icache_top #(
   parameter int SETS_LOG2 = 4,
   parameter int WAYS_LOG2 = 2
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              re,
   input  icache_pkg::addr_t addr,
   input  logic              inv_we,
   input  icache_pkg::addr_t inv_addr,
   output icache_pkg::word_t dout,
   output logic              dout_vld,
   output logic              stall,
   output logic              inv_busy,
   output logic              ar_valid,
   output icache_pkg::addr_t ar_addr,
   input  logic              ar_ready,
   input  logic              r_valid,
   output logic              r_ready,
   input  icache_pkg::word_t r_data
);

   import icache_pkg::*;

   localparam int WAYS = 1 << WAYS_LOG2;
   localparam int TAG_W = ADDR_W - SETS_LOG2 - LINE_BYTES_LOG2;

   logic                           s1_valid;
   addr_t                          s1_addr;
   addr_t                          inv_line_addr;
   addr_t                          cmp_addr;
   icache_state_e                  state;
   logic [SETS_LOG2-1:0]           boot_idx;
   logic [SETS_LOG2-1:0]           in_idx;
   logic [SETS_LOG2-1:0]           s1_idx;
   logic [SETS_LOG2-1:0]           inv_idx;
   logic [SETS_LOG2-1:0]           rd_idx;
   logic [SETS_LOG2-1:0]           wr_idx;
   logic [BEAT_CNT_W-1:0]          rd_word;
   logic                           rd_en;
   logic                           hit;
   logic                           line_done;
   logic [WAYS_LOG2-1:0]           hit_way;
   logic [WAYS_LOG2-1:0]           victim_way;
   logic [WAYS-1:0]                tag_we;
   logic [WAYS-1:0]                rank_we;
   logic [WAYS-1:0][TAG_W:0]       tag_rdata;
   logic [WAYS-1:0][TAG_W:0]       tag_wdata;
   logic [WAYS-1:0][WAYS_LOG2-1:0] rank_rdata;
   logic [WAYS-1:0][WAYS_LOG2-1:0] rank_wdata;

   // Stage-1 register
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         s1_valid <= 1'b0;
      else if (!stall)
         s1_valid <= re;
   end

   always_ff @(posedge clk)
   begin
      if (!stall && re)
         s1_addr <= addr;
   end

   assign in_idx = addr[LINE_BYTES_LOG2 +: SETS_LOG2];
   assign s1_idx = s1_addr[LINE_BYTES_LOG2 +: SETS_LOG2];
   assign inv_idx = inv_line_addr[LINE_BYTES_LOG2 +: SETS_LOG2];

   // Held index, also the write index of the tag store
   always_comb
   begin
      case (state)
         ST_BOOT:
            wr_idx = boot_idx;
         ST_INV_READ, ST_INV_CLEAR:
            wr_idx = inv_idx;
         default:
            wr_idx = s1_idx;
      endcase
   end

   assign rd_idx = stall ? wr_idx : in_idx;
   assign rd_word = stall ? s1_addr[LINE_BYTES_LOG2-1:WORD_BYTES_LOG2]
                          : addr[LINE_BYTES_LOG2-1:WORD_BYTES_LOG2];
   assign rd_en = (!stall && re) || (state == ST_READOUT) || (state == ST_INV_READ);

   // Invalidate compares against its own line, everything else against stage 1
   assign cmp_addr = ((state == ST_INV_READ) || (state == ST_INV_CLEAR)) ? inv_line_addr
                                                                         : s1_addr;

   icache_ctrl #(.SETS_LOG2(SETS_LOG2)) ctrl_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .s1_valid      (s1_valid),
      .s1_addr       (s1_addr),
      .hit           (hit),
      .line_done     (line_done),
      .inv_we        (inv_we),
      .inv_addr      (inv_addr),
      .ar_ready      (ar_ready),
      .state         (state),
      .boot_idx      (boot_idx),
      .inv_line_addr (inv_line_addr),
      .stall         (stall),
      .dout_vld      (dout_vld),
      .inv_busy      (inv_busy),
      .ar_valid      (ar_valid),
      .ar_addr       (ar_addr),
      .r_ready       (r_ready)
   );

   icache_tag_store #(.SETS_LOG2(SETS_LOG2), .WAYS_LOG2(WAYS_LOG2)) tag_store_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd_en      (rd_en),
      .rd_idx     (rd_idx),
      .wr_idx     (wr_idx),
      .tag_we     (tag_we),
      .rank_we    (rank_we),
      .tag_wdata  (tag_wdata),
      .rank_wdata (rank_wdata),
      .tag_rdata  (tag_rdata),
      .rank_rdata (rank_rdata)
   );

   icache_way_select #(.SETS_LOG2(SETS_LOG2), .WAYS_LOG2(WAYS_LOG2)) way_select_inst (
      .state      (state),
      .s1_valid   (s1_valid),
      .s1_addr    (cmp_addr),
      .boot_idx   (boot_idx),
      .tag_rdata  (tag_rdata),
      .rank_rdata (rank_rdata),
      .hit        (hit),
      .hit_way    (hit_way),
      .victim_way (victim_way),
      .tag_we     (tag_we),
      .tag_wdata  (tag_wdata),
      .rank_we    (rank_we),
      .rank_wdata (rank_wdata)
   );

   icache_data_store #(.SETS_LOG2(SETS_LOG2), .WAYS_LOG2(WAYS_LOG2)) data_store_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd_en      (rd_en),
      .rd_addr    ({rd_idx, rd_word}),
      .refill_way (victim_way),
      .refill_set (s1_idx),
      .r_valid    (r_valid),
      .r_ready    (r_ready),
      .r_data     (r_data),
      .hit_way    (hit_way),
      .dout       (dout),
      .line_done  (line_done)
   );

endmodule

//--- tb_icache_assertions.sv
`timescale 1ns/100ps

module tb_icache_assertions (
   input logic clk,
   input logic rst_n,
   input logic ar_valid,
   input logic ar_ready,
   input logic inv_busy,
   input logic dout_vld,
   input logic stall
);

   int fail_cnt = 0;

   // Address request held until the slave accepts it
   ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ar_valid && !ar_ready |=> ar_valid)
      else
      begin
         $error("ar_valid dropped before ar_ready");
         fail_cnt++;
      end

   // INV_READ, INV_CLEAR, READOUT
   inv_len: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(inv_busy) |=> inv_busy ##1 inv_busy ##1 !inv_busy)
      else
      begin
         $error("inv_busy not high for exactly 3 cycles");
         fail_cnt++;
      end

   // Shortest stall is an invalidate, no word comes out before it ends
   vld_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(stall) |-> !dout_vld [*4])
      else
      begin
         $error("dout_vld high within a stall");
         fail_cnt++;
      end

endmodule

//--- tb_icache_checker.sv
`timescale 1ns/100ps

module tb_icache_checker #(
   parameter int SETS_LOG2 = 4,
   parameter int WAYS_LOG2 = 2,
   parameter int MAX_TESTS = 8,
   parameter logic [31:0] MEM_KEY = 32'h0
) (
   input logic              clk,
   input logic              rst_n,
   input int                test_num,
   input logic              dir_chk,
   input logic              dir_hit,
   input logic              re,
   input icache_pkg::addr_t addr,
   input logic              inv_we,
   input icache_pkg::addr_t inv_addr,
   input icache_pkg::word_t dout,
   input logic              dout_vld,
   input logic              stall,
   input logic              inv_busy,
   input logic              ar_valid,
   input icache_pkg::addr_t ar_addr,
   input logic              ar_ready,
   input logic              r_valid,
   input logic              r_ready
);

   import icache_pkg::*;

   localparam int SETS = 1 << SETS_LOG2;
   localparam int WAYS = 1 << WAYS_LOG2;
   localparam int BOOT_CYCLES = SETS;
   localparam int BEATS = 1 << BEAT_CNT_W;

   int    test_errors [MAX_TESTS];
   int    checks;
   logic  valid_m [SETS][WAYS];
   addr_t tag_m [SETS][WAYS];
   int    rank_m [SETS][WAYS];

   // Request between acceptance and dout_vld
   logic  pend;
   logic  p_hit;
   logic  p_dir;
   logic  p_dir_hit;
   logic  got_hit;
   addr_t p_addr;
   int    p_set;
   int    p_way;
   int    p_age;
   int    p_ar;
   int    p_beats;

   int    boot_cnt;
   logic  boot_done;
   logic  inv_exp;
   int    inv_cnt;

   function automatic int set_of(input addr_t a);
      return int'(a[LINE_BYTES_LOG2 +: SETS_LOG2]);
   endfunction

   function automatic addr_t tag_of(input addr_t a);
      return a >> (LINE_BYTES_LOG2 + SETS_LOG2);
   endfunction

   function automatic addr_t line_of(input addr_t a);
      return a & ~addr_t'((1 << LINE_BYTES_LOG2) - 1);
   endfunction

   // Memory content of the word holding byte address a
   function automatic word_t mem_word(input addr_t a);
      return (a & ~addr_t'((1 << WORD_BYTES_LOG2) - 1)) ^ MEM_KEY;
   endfunction

   task automatic mismatch(input string sig, input logic [31:0] exp, input logic [31:0] got);
      $display("Error at %0t ns: %s expected %h, got %h", $time, sig, exp, got);
      test_errors[test_num]++;
   endtask

   task automatic fault(input string what);
      $display("Failure at %0t ns: %s", $time, what);
      test_errors[test_num]++;
   endtask

   // LRU update, used way to the top, ways above its old rank step down
   task automatic touch(input int s, input int w);
      int old;
      old = rank_m[s][w];
      for (int i = 0; i < WAYS; i++)
      begin
         if (i == w)
            rank_m[s][i] = WAYS - 1;
         else if (rank_m[s][i] > old)
            rank_m[s][i]--;
      end
   endtask

   task automatic predict(input addr_t a);
      int    s;
      addr_t t;
      s = set_of(a);
      t = tag_of(a);
      p_hit = 1'b0;
      p_way = 0;
      for (int w = 0; w < WAYS; w++)
      begin
         if (valid_m[s][w] && tag_m[s][w] == t)
         begin
            p_hit = 1'b1;
            p_way = w;
         end
      end
      // Miss takes the rank-0 way and claims it at once
      if (!p_hit)
      begin
         for (int w = 0; w < WAYS; w++)
         begin
            if (rank_m[s][w] == 0)
               p_way = w;
         end
         valid_m[s][p_way] = 1'b1;
         tag_m[s][p_way] = t;
      end
      p_set = s;
   endtask

   initial
   begin
      for (int s = 0; s < SETS; s++)
      begin
         for (int w = 0; w < WAYS; w++)
         begin
            valid_m[s][w] = 1'b0;
            tag_m[s][w] = '0;
            rank_m[s][w] = w;
         end
      end
      for (int i = 0; i < MAX_TESTS; i++)
         test_errors[i] = 0;
      checks = 0;
      pend = 1'b0;
      boot_cnt = 0;
      boot_done = 1'b0;
      inv_exp = 1'b0;
      inv_cnt = 0;
   end

   // Values at the falling edge are the ones the next rising edge sees
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         if (!boot_done && stall)
            boot_cnt++;
         else if (!boot_done)
         begin
            boot_done = 1'b1;
            checks++;
            if (boot_cnt < BOOT_CYCLES)
               mismatch("boot stall cycles", BOOT_CYCLES, boot_cnt);
         end

         if (inv_exp && !inv_busy)
            fault("inv_busy did not rise in the cycle after inv_we");
         inv_exp = 1'b0;
         if (inv_busy)
            inv_cnt++;
         else if (inv_cnt != 0)
         begin
            checks++;
            if (inv_cnt != 3)
               mismatch("inv_busy cycles", 3, inv_cnt);
            inv_cnt = 0;
         end

         if (ar_valid && !(pend && !p_hit))
            fault("ar_valid high without an outstanding miss");
         if (r_ready && !(pend && !p_hit))
            fault("r_ready high without an outstanding miss");

         if (pend)
         begin
            p_age++;
            if (ar_valid && ar_ready)
            begin
               p_ar++;
               checks++;
               if (ar_addr !== line_of(p_addr))
                  mismatch("ar_addr", line_of(p_addr), ar_addr);
            end
            if (r_valid && r_ready)
               p_beats++;
            if (dout_vld)
            begin
               checks++;
               got_hit = (p_age == 1) && (p_ar == 0);
               if (dout !== mem_word(p_addr))
                  mismatch("dout", mem_word(p_addr), dout);
               if (p_ar != (p_hit ? 0 : 1))
                  mismatch("bus requests", p_hit ? 0 : 1, p_ar);
               if (p_beats != (p_hit ? 0 : BEATS))
                  mismatch("refill beats", p_hit ? 0 : BEATS, p_beats);
               if (p_dir && (got_hit != p_dir_hit))
                  mismatch("hit", p_dir_hit, got_hit);
               touch(p_set, p_way);
               pend = 1'b0;
            end
            else if (p_age == 1 && p_hit)
               fault("no dout_vld in the cycle after a hit");
            else if (p_age == 1 && !stall)
               fault("stall low in the cycle after a miss");
         end
         else if (dout_vld)
            fault("dout_vld high without an outstanding request");

         if (re && !stall)
         begin
            if (pend)
               fault("request accepted while the previous one is outstanding");
            p_addr = addr;
            p_age = 0;
            p_ar = 0;
            p_beats = 0;
            p_dir = dir_chk;
            p_dir_hit = dir_hit;
            predict(addr);
            pend = 1'b1;
         end

         if (inv_we && !stall)
         begin
            for (int w = 0; w < WAYS; w++)
            begin
               if (tag_m[set_of(inv_addr)][w] == tag_of(inv_addr))
                  valid_m[set_of(inv_addr)][w] = 1'b0;
            end
            inv_exp = 1'b1;
         end
      end
   end

endmodule

//--- tb_icache.sv
`timescale 1ns/100ps

module tb_icache;

   import icache_pkg::*;

   localparam int SETS_LOG2 = 4;
   localparam int WAYS_LOG2 = 2;
   localparam int BOOT_CYCLES = 1 << SETS_LOG2;
   localparam int BEATS = 1 << BEAT_CNT_W;
   localparam int SEED = 30910;
   localparam int N_RAND = 300;
   localparam int N_DIRECTED = 21;
   localparam int NUM_TESTS = 4;
   localparam int MAX_TESTS = 8;
   localparam int TIMEOUT_CYCLES = (N_RAND + N_DIRECTED) * 20 + BOOT_CYCLES + 5;
   localparam logic [31:0] MEM_KEY = 32'h5A5A_C3C3;
   localparam addr_t BASE = 32'h0004_0000;

   logic  clk;
   logic  rst_n;
   logic  re;
   addr_t addr;
   logic  inv_we;
   addr_t inv_addr;
   word_t dout;
   logic  dout_vld;
   logic  stall;
   logic  inv_busy;
   logic  ar_valid;
   addr_t ar_addr;
   logic  ar_ready;
   logic  r_valid;
   logic  r_ready;
   word_t r_data;

   logic  dir_chk;
   logic  dir_hit;
   int    test_num;
   int    seed = SEED;
   int    bus_seed = SEED + 1;
   int    cycle_cnt;
   int    pick;
   int    total_errors;
   int    a_fails;

   // Bus responder state
   logic  ar_hs;
   logic  r_hs;
   logic  bus_busy;
   addr_t hs_addr;
   addr_t bus_line;
   int    beat_n;

   icache_top #(.SETS_LOG2(SETS_LOG2), .WAYS_LOG2(WAYS_LOG2)) icache_top_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .re       (re),
      .addr     (addr),
      .inv_we   (inv_we),
      .inv_addr (inv_addr),
      .dout     (dout),
      .dout_vld (dout_vld),
      .stall    (stall),
      .inv_busy (inv_busy),
      .ar_valid (ar_valid),
      .ar_addr  (ar_addr),
      .ar_ready (ar_ready),
      .r_valid  (r_valid),
      .r_ready  (r_ready),
      .r_data   (r_data)
   );

   tb_icache_checker #(
      .SETS_LOG2 (SETS_LOG2),
      .WAYS_LOG2 (WAYS_LOG2),
      .MAX_TESTS (MAX_TESTS),
      .MEM_KEY   (MEM_KEY)
   ) checker_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .test_num (test_num),
      .dir_chk  (dir_chk),
      .dir_hit  (dir_hit),
      .re       (re),
      .addr     (addr),
      .inv_we   (inv_we),
      .inv_addr (inv_addr),
      .dout     (dout),
      .dout_vld (dout_vld),
      .stall    (stall),
      .inv_busy (inv_busy),
      .ar_valid (ar_valid),
      .ar_addr  (ar_addr),
      .ar_ready (ar_ready),
      .r_valid  (r_valid),
      .r_ready  (r_ready)
   );

   bind icache_ctrl tb_icache_assertions assertions_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .ar_valid (ar_valid),
      .ar_ready (ar_ready),
      .inv_busy (inv_busy),
      .dout_vld (dout_vld),
      .stall    (stall)
   );

   always #50 clk = ~clk;

   function automatic addr_t make_addr(input int tag, input int set, input int word);
      return BASE + (addr_t'(tag) << (LINE_BYTES_LOG2 + SETS_LOG2))
                  + (addr_t'(set) << LINE_BYTES_LOG2) + (addr_t'(word) << WORD_BYTES_LOG2);
   endfunction

   // Six tags over mostly one set, more lines than ways
   function automatic addr_t pool_addr();
      int tag;
      int sel;
      int word;
      tag = $unsigned($random(seed)) % 6;
      sel = $unsigned($random(seed)) % 4;
      word = $unsigned($random(seed)) % BEATS;
      return make_addr(tag, (sel == 3) ? 12 : 3, word);
   endfunction

   // Returns one cycle after the request is accepted
   task automatic read_req(input addr_t a, input logic known, input logic exp_hit);
      re = 1'b1;
      addr = a;
      dir_chk = known;
      dir_hit = exp_hit;
      @(negedge clk);
      while (stall)
         @(negedge clk);
      @(posedge clk);
      #1;
      re = 1'b0;
      dir_chk = 1'b0;
   endtask

   task automatic idle_cycle();
      re = 1'b0;
      @(posedge clk);
      #1;
   endtask

   // Wait until the last request has completed and stage 1 is empty
   task automatic drain();
      re = 1'b0;
      @(negedge clk);
      while (stall || dout_vld)
         @(negedge clk);
      @(posedge clk);
      #1;
   endtask

   task automatic invalidate(input addr_t a);
      drain();
      inv_we = 1'b1;
      inv_addr = a;
      @(posedge clk);
      #1;
      inv_we = 1'b0;
   endtask

   task automatic finish_test(input string name);
      drain();
      $display("Test %0d %s: %0d errors", test_num + 1, name,
               checker_inst.test_errors[test_num]);
      test_num++;
   endtask

   // Bus slave, line returned in word order with random gaps
   initial
   begin
      ar_ready = 1'b0;
      r_valid = 1'b0;
      r_data = '0;
      bus_busy = 1'b0;
      bus_line = '0;
      beat_n = 0;
      forever
      begin
         @(negedge clk);
         ar_hs = ar_valid && ar_ready;
         r_hs = r_valid && r_ready;
         hs_addr = ar_addr;
         @(posedge clk);
         #1;
         if (r_hs)
            beat_n++;
         if (beat_n == BEATS)
            bus_busy = 1'b0;
         if (ar_hs)
         begin
            bus_line = hs_addr;
            bus_busy = 1'b1;
            beat_n = 0;
         end
         ar_ready = ($unsigned($random(bus_seed)) % 4) != 0;
         r_valid = bus_busy && (($unsigned($random(bus_seed)) % 4) != 0);
         r_data = (bus_line + (beat_n << WORD_BYTES_LOG2)) ^ MEM_KEY;
      end
   end

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, a request or the boot sweep never finished",
               cycle_cnt);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial
   begin
      clk = 1'b0;
      rst_n = 1'b0;
      re = 1'b0;
      addr = '0;
      inv_we = 1'b0;
      inv_addr = '0;
      dir_chk = 1'b0;
      dir_hit = 1'b0;
      test_num = 0;
      total_errors = 0;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Cold cache after the boot sweep
      for (int i = 0; i < 4; i++)
         read_req(make_addr(i, i + 1, i), 1'b1, 1'b0);
      finish_test("boot and cold misses");

      // Five lines in set 7, oldest touched before the fifth
      read_req(make_addr(16, 7, 0), 1'b1, 1'b0);
      read_req(make_addr(17, 7, 1), 1'b1, 1'b0);
      read_req(make_addr(18, 7, 2), 1'b1, 1'b0);
      read_req(make_addr(19, 7, 3), 1'b1, 1'b0);
      read_req(make_addr(16, 7, 1), 1'b1, 1'b1);
      read_req(make_addr(20, 7, 0), 1'b1, 1'b0);
      read_req(make_addr(16, 7, 2), 1'b1, 1'b1);
      read_req(make_addr(17, 7, 3), 1'b1, 1'b0);
      read_req(make_addr(19, 7, 0), 1'b1, 1'b1);
      read_req(make_addr(18, 7, 1), 1'b1, 1'b0);
      finish_test("LRU replacement");

      // Neighbour line in the same set must survive
      read_req(make_addr(30, 9, 0), 1'b1, 1'b0);
      read_req(make_addr(31, 9, 0), 1'b1, 1'b0);
      read_req(make_addr(30, 9, 1), 1'b1, 1'b1);
      invalidate(make_addr(30, 9, 2));
      read_req(make_addr(30, 9, 3), 1'b1, 1'b0);
      read_req(make_addr(31, 9, 1), 1'b1, 1'b1);
      read_req(make_addr(30, 9, 0), 1'b1, 1'b1);
      finish_test("invalidate");

      for (int n = 0; n < N_RAND; n++)
      begin
         pick = $unsigned($random(seed)) % 32;
         if (pick == 0)
            invalidate(pool_addr());
         else if (pick < 8)
            idle_cycle();
         read_req(pool_addr(), 1'b0, 1'b0);
      end
      finish_test("random traffic");

      repeat (2) @(posedge clk);
      for (int i = 0; i < MAX_TESTS; i++)
         total_errors += checker_inst.test_errors[i];
      a_fails = icache_top_inst.ctrl_inst.assertions_inst.fail_cnt;
      $display("Totals: %0d tests, %0d checks, %0d errors, %0d assertion failures",
               NUM_TESTS, checker_inst.checks, total_errors, a_fails);
      if (total_errors == 0 && a_fails == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- list.f
icache_pkg.sv
icache_sdp_ram.sv
icache_tag_store.sv
icache_way_select.sv
icache_data_store.sv
icache_ctrl.sv
icache_top.sv
tb_icache_assertions.sv
tb_icache_checker.sv
tb_icache.sv

//--- Bender.yml
package:
  name: icache

sources:
  - icache_pkg.sv
  - icache_sdp_ram.sv
  - icache_tag_store.sv
  - icache_way_select.sv
  - icache_data_store.sv
  - icache_ctrl.sv
  - icache_top.sv
  - target: test
    files:
      - tb_icache_assertions.sv
      - tb_icache_checker.sv
      - tb_icache.sv
